// File: logic/axil_mem_pkg.sv
`default_nettype none

package axil_mem_pkg;

    // bus widths
    parameter int ADDR_W = 32;
    parameter int DATA_W = 32;
    parameter int STRB_W = DATA_W / 8;

    // AXI response codes
    parameter logic [1:0] RESP_OKAY   = 2'b00;
    parameter logic [1:0] RESP_SLVERR = 2'b10;

    // one memory word, seen whole or as strobe-selected byte lanes
    // lane 0 is bits 7..0
    typedef union packed {
        logic [DATA_W-1:0]      word;
        logic [STRB_W-1:0][7:0] lanes;
    } mem_word_t;

endpackage

`default_nettype wire

// File: logic/access_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module access_fsm (
    input  wire                                clk,
    input  wire                                reset,
    // read address channel
    input  wire  [axil_mem_pkg::ADDR_W-1:0]    araddr,
    input  wire                                arvalid,
    output logic                               arready,
    // read data channel
    output logic [axil_mem_pkg::DATA_W-1:0]    rdata,
    output logic [1:0]                         rresp,
    output logic                               rvalid,
    input  wire                                rready,
    // write address channel
    input  wire  [axil_mem_pkg::ADDR_W-1:0]    awaddr,
    input  wire                                awvalid,
    output logic                               awready,
    // write data channel
    input  wire  [axil_mem_pkg::DATA_W-1:0]    wdata,
    input  wire  [axil_mem_pkg::STRB_W-1:0]    wstrb,
    input  wire                                wvalid,
    output logic                               wready,
    // write response channel
    output logic [1:0]                         bresp,
    output logic                               bvalid,
    input  wire                                bready,
    // latency timer
    output logic                               delay_start,
    input  wire                                delay_done,
    // memory bank
    output logic [axil_mem_pkg::ADDR_W-1:0]    mem_addr,
    output logic                               mem_rd,
    output logic                               mem_wr,
    output logic [axil_mem_pkg::DATA_W-1:0]    mem_wdata,
    output logic [axil_mem_pkg::STRB_W-1:0]    mem_wstrb,
    input  wire  [axil_mem_pkg::DATA_W-1:0]    mem_rdata,
    input  wire                                mem_hit
);

    localparam logic [2:0] ST_IDLE     = 3'd0;
    localparam logic [2:0] ST_RD_WAIT  = 3'd1;
    localparam logic [2:0] ST_RD_FETCH = 3'd2;
    localparam logic [2:0] ST_RD_RESP  = 3'd3;
    localparam logic [2:0] ST_WR_WAIT  = 3'd4;
    localparam logic [2:0] ST_WR_DATA  = 3'd5;
    localparam logic [2:0] ST_WR_RESP  = 3'd6;

    logic [2:0]                      state;
    logic [axil_mem_pkg::ADDR_W-1:0] addr_q;
    logic                            ar_hs;
    logic                            aw_hs;
    logic                            w_hs;

    // a pending read address keeps AW from handshaking in the same cycle
    assign awready = arready && !arvalid;

    assign ar_hs = arvalid && arready;
    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;

    // timer loads on the address handshake edge
    assign delay_start = ar_hs || aw_hs;

    assign mem_addr  = addr_q;
    assign mem_rd    = (state == ST_RD_WAIT) && delay_done;
    assign mem_wr    = w_hs && mem_hit;
    assign mem_wdata = wdata;
    assign mem_wstrb = wstrb;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= ST_IDLE;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (ar_hs) begin
                        arready <= 1'b0;
                        state   <= ST_RD_WAIT;
                    end else if (aw_hs) begin
                        arready <= 1'b0;
                        state   <= ST_WR_WAIT;
                    end else begin
                        arready <= 1'b1;
                    end
                end
                ST_RD_WAIT: begin
                    // mem_rd fires this cycle
                    if (delay_done) begin
                        state <= ST_RD_FETCH;
                    end
                end
                ST_RD_FETCH: begin
                    rvalid <= 1'b1;
                    state  <= ST_RD_RESP;
                end
                ST_RD_RESP: begin
                    if (rready) begin
                        rvalid  <= 1'b0;
                        arready <= 1'b1;
                        state   <= ST_IDLE;
                    end
                end
                ST_WR_WAIT: begin
                    if (delay_done) begin
                        wready <= 1'b1;
                        state  <= ST_WR_DATA;
                    end
                end
                ST_WR_DATA: begin
                    if (w_hs) begin
                        wready <= 1'b0;
                        bvalid <= 1'b1;
                        state  <= ST_WR_RESP;
                    end
                end
                ST_WR_RESP: begin
                    if (bready) begin
                        bvalid  <= 1'b0;
                        arready <= 1'b1;
                        state   <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // address capture and response payload
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            addr_q <= araddr;
        end else if (aw_hs) begin
            addr_q <= awaddr;
        end
        // bank output is valid the cycle after mem_rd
        if (state == ST_RD_FETCH) begin
            rdata <= mem_hit ? mem_rdata : '0;
            rresp <= mem_hit ? axil_mem_pkg::RESP_OKAY : axil_mem_pkg::RESP_SLVERR;
        end
        if (w_hs) begin
            bresp <= mem_hit ? axil_mem_pkg::RESP_OKAY : axil_mem_pkg::RESP_SLVERR;
        end
    end

    a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

    a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bresp));

    a_addr_ready_idle: assert property (@(posedge clk) disable iff (reset)
        (arready || awready) |-> state == ST_IDLE);

endmodule

`default_nettype wire

// File: logic/latency_timer.sv
`timescale 1ns/1ps
`default_nettype none

module latency_timer #(
    parameter int          MAX_DELAY = 8,
    parameter logic [15:0] LFSR_SEED = 16'hACE1
) (
    input  wire  clk,
    input  wire  reset,
    input  wire  delay_start,
    output logic delay_done
);

    localparam int CNT_W = $clog2(MAX_DELAY + 1);

    logic [15:0]      lfsr;
    logic             feedback;
    logic [15:0]      pick;
    logic [CNT_W-1:0] count;

    // taps 16,14,13,11
    assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    // wait in 1..MAX_DELAY
    assign pick = (lfsr % 16'(MAX_DELAY)) + 16'd1;

    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr       <= LFSR_SEED;
            count      <= '0;
            delay_done <= 1'b0;
        end else begin
            lfsr <= {lfsr[14:0], feedback};
            if (delay_start) begin
                count      <= pick[CNT_W-1:0];
                delay_done <= 1'b0;
            end else if (count != '0) begin
                count <= count - 1'b1;
                if (count == CNT_W'(1)) begin
                    delay_done <= 1'b1;
                end
            end
        end
    end

    // the FSM must not restart a wait that is still counting
    a_start_idle: assert property (@(posedge clk) disable iff (reset)
        delay_start |-> count == '0);

endmodule

`default_nettype wire

// File: logic/sram_bank.sv
`timescale 1ns/1ps
`default_nettype none

module sram_bank #(
    parameter logic [axil_mem_pkg::ADDR_W-1:0] MEM_BASE  = 32'h8000_0000,
    parameter int                              MEM_WORDS = 256
) (
    input  wire                                clk,
    input  wire  [axil_mem_pkg::ADDR_W-1:0]    mem_addr,
    input  wire                                mem_rd,
    input  wire                                mem_wr,
    input  wire  [axil_mem_pkg::DATA_W-1:0]    mem_wdata,
    input  wire  [axil_mem_pkg::STRB_W-1:0]    mem_wstrb,
    output logic [axil_mem_pkg::DATA_W-1:0]    mem_rdata,
    output logic                               mem_hit
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam logic [axil_mem_pkg::ADDR_W-3:0] WORD_LIMIT =
        MEM_WORDS[axil_mem_pkg::ADDR_W-3:0];

    axil_mem_pkg::mem_word_t         mem [MEM_WORDS];
    axil_mem_pkg::mem_word_t         wr_word;
    logic [axil_mem_pkg::ADDR_W-1:0] offset;
    logic [axil_mem_pkg::ADDR_W-3:0] word_off;
    logic [IDX_W-1:0]                idx;
    logic                            in_window;

    assign offset   = mem_addr - MEM_BASE;
    assign word_off = offset[axil_mem_pkg::ADDR_W-1:2];
    assign idx      = word_off[IDX_W-1:0];

    // addresses below the base wrap to a large offset,
    // so one compare covers both ends of the window
    assign in_window = word_off < WORD_LIMIT;

    assign wr_word = mem_wdata;

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // byte-lane merge
    always @(posedge clk) begin
        if (mem_wr) begin
            for (int b = 0; b < axil_mem_pkg::STRB_W; b++) begin
                if (mem_wstrb[b]) begin
                    mem[idx].lanes[b] <= wr_word.lanes[b];
                end
            end
        end
    end

    // registered read port, hit follows the captured address
    always_ff @(posedge clk) begin
        if (mem_rd) begin
            mem_rdata <= mem[idx].word;
        end
        mem_hit <= in_window;
    end

endmodule

`default_nettype wire

// File: logic/axil_sram.sv
`timescale 1ns/1ps
`default_nettype none

module axil_sram #(
    parameter logic [axil_mem_pkg::ADDR_W-1:0] MEM_BASE  = 32'h8000_0000,
    parameter int                              MEM_WORDS = 256,
    parameter int                              MAX_DELAY = 8,
    parameter logic [15:0]                     LFSR_SEED = 16'hACE1
) (
    input  wire                                clk,
    input  wire                                reset,
    input  wire  [axil_mem_pkg::ADDR_W-1:0]    araddr,
    input  wire                                arvalid,
    output logic                               arready,
    output logic [axil_mem_pkg::DATA_W-1:0]    rdata,
    output logic [1:0]                         rresp,
    output logic                               rvalid,
    input  wire                                rready,
    input  wire  [axil_mem_pkg::ADDR_W-1:0]    awaddr,
    input  wire                                awvalid,
    output logic                               awready,
    input  wire  [axil_mem_pkg::DATA_W-1:0]    wdata,
    input  wire  [axil_mem_pkg::STRB_W-1:0]    wstrb,
    input  wire                                wvalid,
    output logic                               wready,
    output logic [1:0]                         bresp,
    output logic                               bvalid,
    input  wire                                bready
);

    logic                            delay_start;
    logic                            delay_done;
    logic [axil_mem_pkg::ADDR_W-1:0] mem_addr;
    logic                            mem_rd;
    logic                            mem_wr;
    logic [axil_mem_pkg::DATA_W-1:0] mem_wdata;
    logic [axil_mem_pkg::STRB_W-1:0] mem_wstrb;
    logic [axil_mem_pkg::DATA_W-1:0] mem_rdata;
    logic                            mem_hit;

    access_fsm fsm0 (
        .clk         (clk),
        .reset       (reset),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wvalid      (wvalid),
        .wready      (wready),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bready      (bready),
        .delay_start (delay_start),
        .delay_done  (delay_done),
        .mem_addr    (mem_addr),
        .mem_rd      (mem_rd),
        .mem_wr      (mem_wr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_rdata   (mem_rdata),
        .mem_hit     (mem_hit)
    );

    latency_timer #(
        .MAX_DELAY (MAX_DELAY),
        .LFSR_SEED (LFSR_SEED)
    ) timer0 (
        .clk         (clk),
        .reset       (reset),
        .delay_start (delay_start),
        .delay_done  (delay_done)
    );

    sram_bank #(
        .MEM_BASE  (MEM_BASE),
        .MEM_WORDS (MEM_WORDS)
    ) bank0 (
        .clk       (clk),
        .mem_addr  (mem_addr),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .mem_wdata (mem_wdata),
        .mem_wstrb (mem_wstrb),
        .mem_rdata (mem_rdata),
        .mem_hit   (mem_hit)
    );

endmodule

`default_nettype wire

// File: test/mem_ref_model.svh
`ifndef MEM_REF_MODEL_SVH
`define MEM_REF_MODEL_SVH

// stimulus source, 16-bit Fibonacci LFSR with taps 16,15,13,4
logic [15:0] rng_state = 16'd87;

// one LFSR step per bit, first bit ends up as the msb
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int i = 0; i < n; i++) begin
        fb        = rng_state[15] ^ rng_state[14] ^ rng_state[12] ^ rng_state[3];
        rng_state = {rng_state[14:0], fb};
        value     = {value[30:0], fb};
    end
    return value;
endfunction

// reference copy of the memory window
axil_mem_pkg::mem_word_t model_mem [MEM_WORDS];

task automatic clear_model();
    for (int i = 0; i < MEM_WORDS; i++) begin
        model_mem[i] = '0;
    end
endtask

function automatic logic addr_in_window(input logic [31:0] addr);
    return (addr >= MEM_BASE) && (addr < MEM_BASE + WINDOW_BYTES);
endfunction

function automatic int word_index(input logic [31:0] addr);
    return int'((addr - MEM_BASE) >> 2);
endfunction

// only strobed lanes change, misses leave the model alone
task automatic merge_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    axil_mem_pkg::mem_word_t w;
    int                      idx;
    w.word = data;
    if (addr_in_window(addr)) begin
        idx = word_index(addr);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                model_mem[idx].lanes[b] = w.lanes[b];
            end
        end
    end
endtask

function automatic logic [31:0] lookup_word(input logic [31:0] addr);
    if (addr_in_window(addr)) begin
        return model_mem[word_index(addr)].word;
    end
    return 32'h0;
endfunction

`endif

// File: test/axil_sram_tb.sv
`timescale 1ns/1ps
`default_nettype none

module axil_sram_tb;

    localparam int          CLK_PERIOD      = 10;
    localparam int          RESET_CYCLES    = 4;
    localparam logic [31:0] MEM_BASE        = 32'h8000_0000;
    localparam int          MEM_WORDS       = 256;
    localparam int          MAX_DELAY       = 8;
    localparam logic [31:0] WINDOW_BYTES    = 32'(MEM_WORDS * 4);
    localparam int          N_TRANS         = 400;
    localparam int          LAT_LIMIT       = MAX_DELAY + 3;
    localparam int          ADDR_WAIT_LIMIT = 4;
    localparam int          WATCHDOG_CYCLES = N_TRANS * (MAX_DELAY + 12);

    logic        clk = 1'b0;
    logic        reset;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    int          trans_count;

    `include "mem_ref_model.svh"

    axil_sram #(
        .MEM_BASE  (MEM_BASE),
        .MEM_WORDS (MEM_WORDS),
        .MAX_DELAY (MAX_DELAY)
    ) dut0 (
        .clk     (clk),
        .reset   (reset),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("** Error: %s: expected %h, actual %h", test, expected, actual);
        stop_run();
    endtask

    task automatic report_failure(input string what);
        $display("Error: %s", what);
        stop_run();
    endtask

    task automatic compare_word(input string test, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (actual === expected) else report_mismatch(test, expected, actual);
    endtask

    task automatic compare_bit(input string test, input logic expected, input logic actual);
        assert (actual === expected) else report_mismatch(test, 32'(expected), 32'(actual));
    endtask

    task automatic expect_quiet_outputs(input string label);
        compare_bit({label, " arready"}, 1'b0, arready);
        compare_bit({label, " awready"}, 1'b0, awready);
        compare_bit({label, " rvalid"}, 1'b0, rvalid);
        compare_bit({label, " wready"}, 1'b0, wready);
        compare_bit({label, " bvalid"}, 1'b0, bvalid);
    endtask

    task automatic reset_sequence();
        repeat (RESET_CYCLES - 1) begin
            @(negedge clk);
            expect_quiet_outputs("reset");
        end
        @(negedge clk);
        reset = 1'b0;
        expect_quiet_outputs("first cycle after reset");
        @(negedge clk);
        compare_bit("arready after reset", 1'b1, arready);
        compare_bit("awready after reset", 1'b1, awready);
    endtask

    // one in eight lands just outside either end of the window
    function automatic logic [31:0] pick_addr(input logic [2:0] kind);
        logic [7:0]  k;
        logic [31:0] addr;
        k = 8'(rand_bits(8));
        if (kind == 3'd0) begin
            if (rand_bits(1) == 32'd1) begin
                addr = MEM_BASE + WINDOW_BYTES + {22'b0, k, 2'b00};
            end else begin
                addr = MEM_BASE - 32'd4 - {22'b0, k, 2'b00};
            end
        end else if (kind == 3'd1) begin
            addr = MEM_BASE + {22'b0, k, 2'b00};
        end else begin
            // small hot set so reads often see earlier writes
            addr = MEM_BASE + {22'b0, 4'b0, k[3:0], 2'b00};
        end
        return addr;
    endfunction

    // in-window word that a stray write to addr would have landed on
    function automatic logic [31:0] alias_addr(input logic [31:0] addr);
        return MEM_BASE + ((addr - MEM_BASE) & (WINDOW_BYTES - 32'd1));
    endfunction

    task automatic hold_read_response(input int stall);
        logic [31:0] held_data;
        logic [1:0]  held_resp;
        held_data = rdata;
        held_resp = rresp;
        repeat (stall) begin
            @(negedge clk);
            assert (rvalid) else report_failure("rvalid dropped while rready was low");
            compare_word("read hold data", held_data, rdata);
            compare_word("read hold resp", 32'(held_resp), 32'(rresp));
        end
    endtask

    task automatic hold_write_response(input int stall);
        logic [1:0] held_resp;
        held_resp = bresp;
        repeat (stall) begin
            @(negedge clk);
            assert (bvalid) else report_failure("bvalid dropped while bready was low");
            compare_word("write hold resp", 32'(held_resp), 32'(bresp));
        end
    endtask

    task automatic read_access(input logic [31:0] addr);
        logic [31:0] exp_data;
        logic [1:0]  exp_resp;
        int          waited;
        int          cycles;
        exp_data = lookup_word(addr);
        exp_resp = addr_in_window(addr) ? axil_mem_pkg::RESP_OKAY : axil_mem_pkg::RESP_SLVERR;
        araddr   = addr;
        arvalid  = 1'b1;
        waited   = 0;
        while (!arready && waited < ADDR_WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (arready) else report_failure("arready never rose for a read address");
        @(negedge clk);
        arvalid = 1'b0;
        cycles  = 0;
        while (!rvalid && cycles < LAT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        assert (rvalid) else report_failure("read response took longer than its bound");
        hold_read_response(int'(rand_bits(2)));
        rready = 1'b1;
        compare_word("read data", exp_data, rdata);
        compare_word("read resp", 32'(exp_resp), 32'(rresp));
        @(negedge clk);
        rready = 1'b0;
        compare_bit("rvalid after accept", 1'b0, rvalid);
        trans_count++;
    endtask

    task automatic write_access(input logic [31:0] addr, input logic [31:0] data,
                                input logic [3:0] strb);
        logic [1:0] exp_resp;
        int         waited;
        int         cycles;
        exp_resp = addr_in_window(addr) ? axil_mem_pkg::RESP_OKAY : axil_mem_pkg::RESP_SLVERR;
        awaddr   = addr;
        awvalid  = 1'b1;
        waited   = 0;
        while (!awready && waited < ADDR_WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (awready) else report_failure("awready never rose for a write address");
        @(negedge clk);
        awvalid = 1'b0;
        wdata   = data;
        wstrb   = strb;
        wvalid  = 1'b1;
        cycles  = 0;
        while (!wready && cycles < LAT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        assert (wready) else report_failure("wready took longer than its bound");
        @(negedge clk);
        cycles++;
        wvalid = 1'b0;
        while (!bvalid && cycles < LAT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        assert (bvalid) else report_failure("write response took longer than its bound");
        merge_write(addr, data, strb);
        hold_write_response(int'(rand_bits(2)));
        bready = 1'b1;
        compare_word("write resp", 32'(exp_resp), 32'(bresp));
        @(negedge clk);
        bready = 1'b0;
        compare_bit("bvalid after accept", 1'b0, bvalid);
        trans_count++;
    endtask

    task automatic run_transaction();
        logic [2:0]  kind;
        logic        is_write;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        kind     = 3'(rand_bits(3));
        is_write = 1'(rand_bits(1));
        addr     = pick_addr(kind);
        if (is_write) begin
            data = rand_bits(32);
            strb = 4'(rand_bits(4));
            write_access(addr, data, strb);
            if (!addr_in_window(addr)) begin
                read_access(alias_addr(addr));
            end else if (rand_bits(1) == 32'd1) begin
                read_access(addr);
            end
        end else begin
            read_access(addr);
        end
    endtask

    initial begin
        reset       = 1'b1;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wstrb       = '0;
        wvalid      = 1'b0;
        bready      = 1'b0;
        trans_count = 0;
        clear_model();
        reset_sequence();
        while (trans_count < N_TRANS) begin
            run_transaction();
        end
        @(negedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_failure("run timed out before all transactions finished");
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+test
logic/axil_mem_pkg.sv
logic/access_fsm.sv
logic/latency_timer.sv
logic/sram_bank.sv
logic/axil_sram.sv
test/axil_sram_tb.sv

// File: Makefile
VERILATOR  := verilator
SIM_FLAGS  := --binary --timing --assert
LINT_FLAGS := --lint-only --timing --assert
TOP        := axil_sram_tb
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "sim: pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
